// ==== verilog/pipePkg.sv ====
package pipePkg;

  typedef logic [4:0]  regAddrT;
  typedef logic [31:0] dataT;

  // instruction word views, msb first
  typedef struct packed {
    logic [6:0] funct7;
    regAddrT    rs2;
    regAddrT    rs1;
    logic [2:0] funct3;
    regAddrT    rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm12;
    regAddrT     rs1;
    logic [2:0]  funct3;
    regAddrT     rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] immHi;
    regAddrT    rs2;
    regAddrT    rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sTypeT;

  typedef struct packed {
    logic [19:0] imm20;
    regAddrT     rd;
    logic [6:0]  opcode;
  } uTypeT;

  typedef union packed {
    rTypeT rType;
    iTypeT iType;
    sTypeT sType;
    uTypeT uType;
  } instWordT;

  typedef enum logic [3:0] {
    aluNop, aluAdd, aluSub, aluAnd, aluOr, aluXor,
    aluSll, aluSrl, aluSra, aluSlt, aluSltu
  } aluOpT;

  typedef enum logic [1:0] {opNone, opReg, opImm, opPc} opTypeT;

  typedef struct packed {
    aluOpT  aluOp;
    opTypeT op1Type;
    opTypeT op2Type;
  } aluCtrlT;

  typedef struct packed {
    dataT     pc;
    instWordT inst;
  } fetchPipeT;

  typedef struct packed {
    regAddrT rs1Addr;
    regAddrT rs2Addr;
    regAddrT rdAddr;
    dataT    imm;
    aluCtrlT aluCtrl;
    logic    wEnable;
    logic    isLoad;
    logic    isStore;
    logic    isHalt;
  } decodeOutT;

  typedef struct packed {
    dataT    pc;
    dataT    rs1Data;
    dataT    rs2Data;
    dataT    imm;
    regAddrT rdAddr;
    aluCtrlT aluCtrl;
    logic    wEnable;
    logic    isStore;
    logic    isLoad;
    logic    isHalt;
  } exPipeT;

  typedef struct packed {
    logic    wEnable;
    regAddrT rdAddr;
    dataT    data;
  } wbPortT;

  localparam exPipeT exBubble = '0; // nop record, no write

  localparam logic [6:0] opcOp     = 7'b0110011;
  localparam logic [6:0] opcOpImm  = 7'b0010011;
  localparam logic [6:0] opcLoad   = 7'b0000011;
  localparam logic [6:0] opcStore  = 7'b0100011;
  localparam logic [6:0] opcLui    = 7'b0110111;
  localparam logic [6:0] opcAuipc  = 7'b0010111;
  localparam logic [6:0] opcSystem = 7'b1110011; // ecall used as halt

endpackage

// ==== verilog/instDecoder.sv ====
`timescale 1ns/1ns

module instDecoder (
  input  pipePkg::instWordT  inst,
  output pipePkg::decodeOutT dec
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic          altBit; // inst[30], selects sub / sra
  pipePkg::dataT immI;
  pipePkg::dataT immS;
  pipePkg::dataT immU;
  pipePkg::dataT shamt;

  assign opcode = inst.rType.opcode;
  assign funct3 = inst.rType.funct3;
  assign altBit = inst.rType.funct7[5];

  assign immI  = {{20{inst.iType.imm12[11]}}, inst.iType.imm12};
  assign immS  = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
  assign immU  = {inst.uType.imm20, 12'h000};
  assign shamt = {27'd0, inst.iType.imm12[4:0]}; // shift amount only, funct7 stripped

  function automatic pipePkg::aluOpT aluOpOf(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  aluOpOf = alt ? pipePkg::aluSub : pipePkg::aluAdd;
      3'b001:  aluOpOf = pipePkg::aluSll;
      3'b010:  aluOpOf = pipePkg::aluSlt;
      3'b011:  aluOpOf = pipePkg::aluSltu;
      3'b100:  aluOpOf = pipePkg::aluXor;
      3'b101:  aluOpOf = alt ? pipePkg::aluSra : pipePkg::aluSrl;
      3'b110:  aluOpOf = pipePkg::aluOr;
      default: aluOpOf = pipePkg::aluAnd;
    endcase
  endfunction

  always_comb begin
    dec = '0; // unknown opcode stays a no-write nop
    case (opcode)
      pipePkg::opcOp: begin
        dec.rs1Addr = inst.rType.rs1;
        dec.rs2Addr = inst.rType.rs2;
        dec.rdAddr  = inst.rType.rd;
        dec.aluCtrl = '{aluOp: aluOpOf(funct3, altBit),
                        op1Type: pipePkg::opReg, op2Type: pipePkg::opReg};
        dec.wEnable = 1'b1;
      end
      pipePkg::opcOpImm: begin
        dec.rs1Addr = inst.iType.rs1;
        dec.rdAddr  = inst.iType.rd;
        dec.imm     = (funct3 == 3'b001 || funct3 == 3'b101) ? shamt : immI;
        // addi never becomes sub, only srai uses the alt bit
        dec.aluCtrl = '{aluOp: aluOpOf(funct3, funct3 == 3'b101 && altBit),
                        op1Type: pipePkg::opReg, op2Type: pipePkg::opImm};
        dec.wEnable = 1'b1;
      end
      pipePkg::opcLoad: begin
        dec.rs1Addr = inst.iType.rs1;
        dec.rdAddr  = inst.iType.rd;
        dec.imm     = immI;
        dec.aluCtrl = '{aluOp: pipePkg::aluAdd,
                        op1Type: pipePkg::opReg, op2Type: pipePkg::opImm};
        dec.wEnable = 1'b1;
        dec.isLoad  = 1'b1;
      end
      pipePkg::opcStore: begin
        dec.rs1Addr = inst.sType.rs1;
        dec.rs2Addr = inst.sType.rs2; // store data, not an alu operand
        dec.imm     = immS;
        dec.aluCtrl = '{aluOp: pipePkg::aluAdd,
                        op1Type: pipePkg::opReg, op2Type: pipePkg::opImm};
        dec.isStore = 1'b1;
      end
      pipePkg::opcLui: begin
        dec.rdAddr  = inst.uType.rd;
        dec.imm     = immU;
        dec.aluCtrl = '{aluOp: pipePkg::aluAdd,
                        op1Type: pipePkg::opNone, op2Type: pipePkg::opImm};
        dec.wEnable = 1'b1;
      end
      pipePkg::opcAuipc: begin
        dec.rdAddr  = inst.uType.rd;
        dec.imm     = immU;
        dec.aluCtrl = '{aluOp: pipePkg::aluAdd,
                        op1Type: pipePkg::opPc, op2Type: pipePkg::opImm};
        dec.wEnable = 1'b1;
      end
      pipePkg::opcSystem: begin
        // only ecall halts, ebreak and csr ops fall through as nop
        dec.isHalt = (funct3 == 3'b000 && inst.iType.imm12 == 12'h000);
      end
      default: begin
        dec = '0;
      end
    endcase
  end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ns

module regFile #(
  parameter bit wbBypass = 1'b0
) (
  input  logic             clk,
  input  logic             rstN,
  input  pipePkg::regAddrT rs1Addr,
  input  pipePkg::regAddrT rs2Addr,
  output pipePkg::dataT    rs1Data,
  output pipePkg::dataT    rs2Data,
  output logic             rs1Ready,
  output logic             rs2Ready,
  input  pipePkg::wbPortT  issue,
  input  pipePkg::wbPortT  wb
);

  pipePkg::dataT regs [32];
  logic [31:0]   readyBits; // scoreboard, bit 0 never cleared

  function automatic logic wbHit(input pipePkg::regAddrT addr);
    wbHit = wbBypass && wb.wEnable && (wb.rdAddr == addr);
  endfunction

  function automatic pipePkg::dataT readData(input pipePkg::regAddrT addr);
    if (addr == '0) begin
      readData = '0;
    end else if (wbHit(addr)) begin
      readData = wb.data; // same-cycle write bypass
    end else begin
      readData = regs[addr];
    end
  endfunction

  // a newer writer still sitting in exPipe overrides any write-back
  function automatic logic readReady(input pipePkg::regAddrT addr);
    logic pending;
    pending = issue.wEnable && (issue.rdAddr == addr);
    if (addr == '0) begin
      readReady = 1'b1;
    end else begin
      readReady = (readyBits[addr] || wbHit(addr)) && !pending;
    end
  endfunction

  always_comb begin
    rs1Data  = readData(rs1Addr);
    rs2Data  = readData(rs2Addr);
    rs1Ready = readReady(rs1Addr);
    rs2Ready = readReady(rs2Addr);
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      readyBits <= '1;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb.wEnable && wb.rdAddr != '0) begin
        regs[wb.rdAddr]      <= wb.data;
        readyBits[wb.rdAddr] <= 1'b1;
      end
      if (issue.wEnable && issue.rdAddr != '0) begin
        readyBits[issue.rdAddr] <= 1'b0; // wins over a same-cycle write-back
      end
    end
  end

endmodule

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
  input  logic               clk,
  input  logic               rstN,
  input  pipePkg::fetchPipeT fetch,
  input  pipePkg::decodeOutT dec,
  input  pipePkg::dataT      rs1Data,
  input  pipePkg::dataT      rs2Data,
  input  logic               rs1Ready,
  input  logic               rs2Ready,
  output pipePkg::regAddrT   rs1Addr,
  output pipePkg::regAddrT   rs2Addr,
  output pipePkg::wbPortT    issue,
  output logic               dataHazard,
  output pipePkg::exPipeT    exPipe
);

  logic            rs1Stall;
  logic            rs2Stall;
  pipePkg::exPipeT nextEx;

  assign rs1Addr = dec.rs1Addr;
  assign rs2Addr = dec.rs2Addr;

  // rs2 of a store is needed even though op2 is the immediate
  assign rs1Stall = (dec.aluCtrl.op1Type == pipePkg::opReg) && !rs1Ready;
  assign rs2Stall = ((dec.aluCtrl.op2Type == pipePkg::opReg) || dec.isStore) && !rs2Ready;

  assign dataHazard = rs1Stall || rs2Stall; // level, fetch holds its word

  always_comb begin
    nextEx.pc      = fetch.pc;
    nextEx.rs1Data = rs1Data;
    nextEx.rs2Data = rs2Data;
    nextEx.imm     = dec.imm;
    nextEx.rdAddr  = dec.rdAddr;
    nextEx.aluCtrl = dec.aluCtrl;
    nextEx.wEnable = dec.wEnable;
    nextEx.isStore = dec.isStore;
    nextEx.isLoad  = dec.isLoad;
    nextEx.isHalt  = dec.isHalt;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exPipe <= pipePkg::exBubble;
    end else if (dataHazard) begin
      exPipe <= pipePkg::exBubble; // insert bubble while waiting
    end else begin
      exPipe <= nextEx;
    end
  end

  // in-flight destination goes back to the scoreboard
  assign issue.wEnable = exPipe.wEnable;
  assign issue.rdAddr  = exPipe.rdAddr;
  assign issue.data    = '0; // unused by the scoreboard

endmodule

// ==== verilog/decodeCore.sv ====
`timescale 1ns/1ns

module decodeCore #(
  parameter bit wbBypass = 1'b1
) (
  input  logic               clk,
  input  logic               rstN,
  input  pipePkg::fetchPipeT fetch,
  input  pipePkg::wbPortT    wb,
  output pipePkg::exPipeT    exPipe,
  output logic               dataHazard
);

  pipePkg::decodeOutT dec;
  pipePkg::regAddrT   rs1Addr;
  pipePkg::regAddrT   rs2Addr;
  pipePkg::dataT      rs1Data;
  pipePkg::dataT      rs2Data;
  logic               rs1Ready;
  logic               rs2Ready;
  pipePkg::wbPortT    issue; // exPipe destination, no data

  instDecoder u_instDecoder (
    .inst (fetch.inst),
    .dec  (dec)
  );

  decodeStage u_decodeStage (
    .clk        (clk),
    .rstN       (rstN),
    .fetch      (fetch),
    .dec        (dec),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .rs1Ready   (rs1Ready),
    .rs2Ready   (rs2Ready),
    .rs1Addr    (rs1Addr),
    .rs2Addr    (rs2Addr),
    .issue      (issue),
    .dataHazard (dataHazard),
    .exPipe     (exPipe)
  );

  regFile #(
    .wbBypass (wbBypass)
  ) u_regFile (
    .clk      (clk),
    .rstN     (rstN),
    .rs1Addr  (rs1Addr),
    .rs2Addr  (rs2Addr),
    .rs1Data  (rs1Data),
    .rs2Data  (rs2Data),
    .rs1Ready (rs1Ready),
    .rs2Ready (rs2Ready),
    .issue    (issue),
    .wb       (wb)
  );

endmodule

// ==== testbench/decodeCore_chk.sv ====
`timescale 1ns/1ns

module decodeCore_chk (
  input logic             clk,
  input logic             rstN,
  input pipePkg::exPipeT  exPipe,
  input logic             dataHazard,
  input pipePkg::regAddrT rs1Addr,
  input pipePkg::regAddrT rs2Addr,
  input pipePkg::dataT    rs1Data,
  input pipePkg::dataT    rs2Data
);

  hazardGivesBubble: assert property (@(posedge clk) disable iff (!rstN)
    dataHazard |=> exPipe == pipePkg::exBubble)
    else $error("bubble missing after a hazard cycle");

  noWriteAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> !exPipe.wEnable)
    else $error("exPipe writes right after reset");

  storeNeverWritesX0: assert property (@(posedge clk) disable iff (!rstN)
    !(exPipe.rdAddr == '0 && exPipe.isStore && exPipe.wEnable))
    else $error("store record with a write to x0");

  x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
    (rs1Addr == '0 -> rs1Data == '0) && (rs2Addr == '0 -> rs2Data == '0))
    else $error("x0 read returned nonzero data");

endmodule

bind decodeCore decodeCore_chk u_decodeCoreChk (.*);

// ==== testbench/decodeCoreTb.sv ====
`timescale 1ns/1ns

module decodeCoreTb;

  localparam bit bypass    = 1'b1;
  localparam int waitLimit = 20; // cycles a word may stay on hold

  logic               clk;
  logic               rstN;
  pipePkg::fetchPipeT fetch;
  pipePkg::wbPortT    wb;
  pipePkg::exPipeT    exPipe;
  logic               dataHazard;

  pipePkg::dataT   shadowRegs [32];
  logic [31:0]     shadowReady; // model scoreboard
  pipePkg::exPipeT expEx;       // predicted exPipe contents
  pipePkg::wbPortT pendWb;      // write-back owed for the last issued rd
  pipePkg::dataT   pcNext;
  int              errors;
  int              checks;

  decodeCore #(.wbBypass(bypass)) u_decodeCore (
    .clk        (clk),
    .rstN       (rstN),
    .fetch      (fetch),
    .wb         (wb),
    .exPipe     (exPipe),
    .dataHazard (dataHazard)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkVal(input string name, input logic [159:0] got, input logic [159:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finishRun();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  function automatic logic srcReady(input pipePkg::regAddrT a);
    logic hit;
    logic busy;
    hit  = bypass && wb.wEnable && (wb.rdAddr == a);
    busy = expEx.wEnable && (expEx.rdAddr == a); // writer still in exPipe
    if (a == '0) begin
      return 1'b1;
    end
    return (shadowReady[a] || hit) && !busy;
  endfunction

  function automatic pipePkg::dataT srcData(input pipePkg::regAddrT a);
    if (a == '0) begin
      return '0;
    end else if (bypass && wb.wEnable && wb.rdAddr == a) begin
      return wb.data;
    end
    return shadowRegs[a];
  endfunction

  // RV32I funct3 meaning, alt is instruction bit 30
  function automatic pipePkg::aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? pipePkg::aluSub : pipePkg::aluAdd;
      3'd1:    return pipePkg::aluSll;
      3'd2:    return pipePkg::aluSlt;
      3'd3:    return pipePkg::aluSltu;
      3'd4:    return pipePkg::aluXor;
      3'd5:    return alt ? pipePkg::aluSra : pipePkg::aluSrl;
      3'd6:    return pipePkg::aluOr;
      default: return pipePkg::aluAnd;
    endcase
  endfunction

  function automatic pipePkg::exPipeT refDecode(input pipePkg::dataT pc,
                                                input logic [31:0] inst,
                                                output logic hazard);
    pipePkg::exPipeT  rec;
    pipePkg::regAddrT r1;
    pipePkg::regAddrT r2;
    logic [6:0]       opc;
    logic [2:0]       f3;
    pipePkg::dataT    immI;
    opc  = inst[6:0];
    f3   = inst[14:12];
    immI = {{20{inst[31]}}, inst[31:20]};
    rec  = '0;
    rec.pc = pc;
    r1 = '0;
    r2 = '0;
    case (opc)
      pipePkg::opcOp: begin
        r1 = inst[19:15];
        r2 = inst[24:20];
        rec.rdAddr  = inst[11:7];
        rec.aluCtrl = '{aluFromFunct(f3, inst[30]), pipePkg::opReg, pipePkg::opReg};
        rec.wEnable = 1'b1;
      end
      pipePkg::opcOpImm: begin
        r1 = inst[19:15];
        rec.rdAddr  = inst[11:7];
        rec.imm     = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, inst[24:20]} : immI;
        rec.aluCtrl = '{aluFromFunct(f3, f3 == 3'd5 && inst[30]),
                        pipePkg::opReg, pipePkg::opImm};
        rec.wEnable = 1'b1;
      end
      pipePkg::opcLoad: begin
        r1 = inst[19:15];
        rec.rdAddr  = inst[11:7];
        rec.imm     = immI;
        rec.aluCtrl = '{pipePkg::aluAdd, pipePkg::opReg, pipePkg::opImm};
        rec.wEnable = 1'b1;
        rec.isLoad  = 1'b1;
      end
      pipePkg::opcStore: begin
        r1 = inst[19:15];
        r2 = inst[24:20];
        rec.imm     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        rec.aluCtrl = '{pipePkg::aluAdd, pipePkg::opReg, pipePkg::opImm};
        rec.isStore = 1'b1;
      end
      pipePkg::opcLui, pipePkg::opcAuipc: begin
        rec.rdAddr  = inst[11:7];
        rec.imm     = {inst[31:12], 12'h000};
        rec.aluCtrl = '{pipePkg::aluAdd,
                        (opc == pipePkg::opcLui) ? pipePkg::opNone : pipePkg::opPc,
                        pipePkg::opImm};
        rec.wEnable = 1'b1;
      end
      pipePkg::opcSystem: begin
        rec.isHalt = (f3 == 3'd0) && (inst[31:20] == 12'h000); // ecall only
      end
      default: begin
        rec.isHalt = 1'b0;
      end
    endcase
    rec.rs1Data = srcData(r1);
    rec.rs2Data = srcData(r2);
    hazard = (rec.aluCtrl.op1Type == pipePkg::opReg && !srcReady(r1)) ||
             ((rec.aluCtrl.op2Type == pipePkg::opReg || rec.isStore) && !srcReady(r2));
    return rec;
  endfunction

  // compare, then advance the model as the edge does
  always @(posedge clk) begin : compareProc
    pipePkg::exPipeT nextEx;
    logic            hz;
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        shadowRegs[i] = '0;
      end
      shadowReady = '1;
      expEx       = '0;
    end else begin
      nextEx = refDecode(fetch.pc, fetch.inst, hz);
      checkVal("dataHazard", 160'(dataHazard), 160'(hz));
      checkVal("exPipe", 160'(exPipe), 160'(expEx));
      if (hz) begin
        nextEx = '0;
      end
      if (wb.wEnable && wb.rdAddr != '0) begin
        shadowRegs[wb.rdAddr]  = wb.data;
        shadowReady[wb.rdAddr] = 1'b1;
      end
      if (expEx.wEnable && expEx.rdAddr != '0) begin
        shadowReady[expEx.rdAddr] = 1'b0; // issue beats write-back
      end
      expEx = nextEx;
    end
  end

  function automatic logic [31:0] rEnc(input logic alt, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, pipePkg::opcOp};
  endfunction

  function automatic logic [31:0] iEnc(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] sEnc(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], pipePkg::opcStore};
  endfunction

  // write-back record owed by an instruction, random data
  function automatic pipePkg::wbPortT wbFor(input logic [31:0] inst);
    pipePkg::wbPortT rec;
    logic [6:0]      opc;
    opc = inst[6:0];
    rec = '0;
    rec.wEnable = (opc == pipePkg::opcOp || opc == pipePkg::opcOpImm ||
                   opc == pipePkg::opcLoad || opc == pipePkg::opcLui ||
                   opc == pipePkg::opcAuipc) && inst[11:7] != 5'd0;
    rec.rdAddr = inst[11:7];
    rec.data   = $urandom;
    return rec;
  endfunction

  task automatic present(input logic [31:0] inst);
    @(negedge clk);
    fetch.pc   = pcNext;
    fetch.inst = inst;
    wb         = pendWb;
    pendWb     = '0;
    pcNext     = pcNext + 32'd4;
  endtask

  task automatic waitAccept(input string what);
    int cnt;
    cnt = 0;
    @(posedge clk);
    while (dataHazard && cnt < waitLimit) begin
      cnt++;
      @(posedge clk);
    end
    if (dataHazard) begin
      errors++;
      $display("timeout: %s word stayed on hazard hold", what);
      finishRun();
    end
  endtask

  task automatic idle();
    @(negedge clk);
    fetch.pc   = pcNext;
    fetch.inst = '0; // unknown opcode, no write
    wb         = '0;
    pcNext     = pcNext + 32'd4;
    @(posedge clk);
  endtask

  task automatic runStep(input logic [31:0] inst);
    present(inst);
    waitAccept("runStep");
    pendWb = wbFor(inst);
    idle();
  endtask

  // consumer issued right behind its producer, held until write-back
  task automatic hazardPair(input logic [31:0] instA, input logic [31:0] instB,
                            input int stalls);
    present(instA);
    waitAccept("producer");
    present(instB);
    for (int n = 0; n < stalls; n++) begin
      @(posedge clk);
      checkVal("dataHazard hold", 160'(dataHazard), 160'(1));
    end
    @(negedge clk);
    wb = wbFor(instA);
    waitAccept("consumer");
    pendWb = wbFor(instB);
    idle();
  endtask

  task automatic backToBack(input logic [31:0] i1, input logic [31:0] i2);
    present(i1);
    @(posedge clk);
    checkVal("dataHazard x0", 160'(dataHazard), 160'(0));
    present(i2);
    @(posedge clk);
    checkVal("dataHazard x0", 160'(dataHazard), 160'(0));
    pendWb = wbFor(i2);
    idle();
  endtask

  initial begin
    logic [2:0] f3;
    void'($urandom(76));
    rstN   = 1'b0;
    fetch  = '0;
    wb     = '0;
    pendWb = '0;
    pcNext = 32'h0000_1000;
    errors = 0;
    checks = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    for (int r = 1; r < 32; r += 2) begin
      runStep(rEnc(1'b0, 5'(r + 1), 5'(r), 3'd0, 5'd0)); // every register still zero
    end

    runStep(rEnc(1'b0, 5'd3, 5'd31, 3'd0, 5'd4)); // fresh registers read zero
    runStep(iEnc(12'hfff, 5'd17, 3'd4, 5'd9, pipePkg::opcOpImm));

    for (int k = 0; k < 60; k++) begin
      f3 = 3'($urandom);
      if ($urandom % 2 == 0) begin
        runStep(rEnc(1'($urandom), 5'($urandom), 5'($urandom), f3, 5'($urandom)));
      end else begin
        runStep(iEnc(12'($urandom), 5'($urandom), f3, 5'($urandom), pipePkg::opcOpImm));
      end
    end

    hazardPair(rEnc(1'b0, 5'd2, 5'd1, 3'd0, 5'd5), rEnc(1'b1, 5'd7, 5'd5, 3'd0, 5'd6), 3);
    hazardPair(iEnc(12'h123, 5'd3, 3'd0, 5'd8, pipePkg::opcOpImm),
               rEnc(1'b0, 5'd8, 5'd9, 3'd6, 5'd11), 1);

    // store waits on rs2 although op2 is the immediate
    hazardPair(iEnc(12'h010, 5'd4, 3'd2, 5'd10, pipePkg::opcLoad),
               sEnc(12'h8a4, 5'd10, 5'd0), 2);
    runStep(iEnc(12'h804, 5'd12, 3'd2, 5'd13, pipePkg::opcLoad));
    runStep(sEnc(12'h7fc, 5'd13, 5'd14));
    runStep({20'hdead0, 5'd15, pipePkg::opcLui});
    runStep({20'h80001, 5'd16, pipePkg::opcAuipc});
    runStep(32'h0000_0073); // ecall, halt
    runStep(32'h0010_0073); // ebreak, plain nop
    runStep(32'h0000_006f); // jal, unsupported
    runStep(32'hffff_ffff);

    backToBack(iEnc(12'h055, 5'd5, 3'd0, 5'd0, pipePkg::opcOpImm),
               rEnc(1'b0, 5'd0, 5'd0, 3'd0, 5'd0));
    backToBack(rEnc(1'b0, 5'd6, 5'd5, 3'd7, 5'd0), rEnc(1'b0, 5'd0, 5'd0, 3'd4, 5'd20));

    idle();
    idle();
    finishRun();
  end

endmodule

// ==== decodeCore.f ====
verilog/pipePkg.sv
verilog/instDecoder.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/decodeCore.sv
testbench/decodeCore_chk.sv
testbench/decodeCoreTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = decodeCoreTb
FILELIST = decodeCore.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
